//--- Makefile
# Verilator build and run of the fetch testbench

SRCS := $(wildcard design/*.sv test/*.sv)

.PHONY: all run clean

all: obj_dir/Vfetch_tb

obj_dir/Vfetch_tb: vlog.f $(SRCS)
	verilator --binary --assert -f vlog.f --top-module fetch_tb -Mdir obj_dir -o Vfetch_tb

run: obj_dir/Vfetch_tb test/program.hex
	./obj_dir/Vfetch_tb

clean:
	rm -rf obj_dir

//--- design/fetch_fifo.sv
// Fetch tag store
// Circular buffer of fetch contexts (uuid, wid, tmask, pc) with flush,
// head entry always visible on the output
`timescale 1ns/1ps

module fetch_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   push,
    input  logic                   pop,
    input  fetch_pkg::fetch_data_t data_in,
    output fetch_pkg::fetch_data_t data_out
);
    import fetch_pkg::*;

    logic [UUID_WIDTH-1:0] uuid_mem [IBUF_SIZE];
    logic [NW_WIDTH-1:0] wid_mem [IBUF_SIZE];
    logic [THREAD_CNT-1:0] tmask_mem [IBUF_SIZE];
    logic [XLEN-1:0] pc_mem [IBUF_SIZE];
    logic [$clog2(IBUF_SIZE)-1:0] wr_ptr;
    logic [$clog2(IBUF_SIZE)-1:0] rd_ptr;

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            uuid_mem[wr_ptr]  <= data_in.uuid;
            wid_mem[wr_ptr]   <= data_in.wid;
            tmask_mem[wr_ptr] <= data_in.tmask;
            pc_mem[wr_ptr]    <= data_in.pc;
        end
    end

    assign data_out.uuid  = uuid_mem[rd_ptr];
    assign data_out.wid   = wid_mem[rd_ptr];
    assign data_out.tmask = tmask_mem[rd_ptr];
    assign data_out.pc    = pc_mem[rd_ptr];
    // the instruction word comes from the cache, never from here
    assign data_out.instr = '0;

endmodule

//--- design/fetch_pkg.sv
// Fetch stage package
// Core sizes for the multi-warp fetch path and the structs that travel on
// the schedule, instruction cache and fetch channels
package fetch_pkg;

    localparam int NUM_WARPS       = 4;
    localparam int NW_WIDTH        = $clog2(NUM_WARPS);
    // a warp issues on slot (wid modulo ISSUE_WIDTH)
    localparam int ISSUE_WIDTH     = 2;
    localparam int THREAD_CNT      = 4;
    localparam int XLEN            = 32;
    localparam int UUID_WIDTH      = 8;
    localparam int IBUF_SIZE       = 4;
    localparam int IMEM_WORDS      = 32;
    localparam int IMEM_ADDR_WIDTH = XLEN - 2;

    // counts entries up to and including IBUF_SIZE
    typedef logic [$clog2(IBUF_SIZE + 1)-1:0] ibuf_cnt_t;

    typedef struct packed {
        logic [UUID_WIDTH-1:0] uuid;
        logic [NW_WIDTH-1:0]   wid;
        logic [THREAD_CNT-1:0] tmask;
        logic [XLEN-1:0]       pc;
    } sched_req_t;

    typedef struct packed {
        logic [UUID_WIDTH-1:0] uuid;
        logic [NW_WIDTH-1:0]   wid;
    } icache_tag_t;

    typedef struct packed {
        logic [IMEM_ADDR_WIDTH-1:0] addr;
        icache_tag_t                tag;
    } icache_req_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        icache_tag_t     tag;
    } icache_rsp_t;

    typedef struct packed {
        logic [UUID_WIDTH-1:0] uuid;
        logic [NW_WIDTH-1:0]   wid;
        logic [THREAD_CNT-1:0] tmask;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
    } fetch_data_t;

endpackage

//--- design/fetch_req_buffer.sv
// Cache request skid buffer
// Two entries: a registered output stage plus one overflow slot, so the
// cache bus sees a flopped request and in_ready comes straight from a flop
`timescale 1ns/1ps

module fetch_req_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   in_valid,
    input  fetch_pkg::icache_req_t in_data,
    output logic                   in_ready,
    output logic                   out_valid,
    output fetch_pkg::icache_req_t out_data,
    input  logic                   out_ready
);
    import fetch_pkg::*;

    icache_req_t skid_data;
    logic skid_valid;
    logic out_load;

    // full only when the overflow slot is occupied
    assign in_ready = !skid_valid;

    // output register can take a new entry when it is empty or draining
    assign out_load = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            // the skid entry goes first, input is blocked while it is held
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data <= skid_valid ? skid_data : in_data;
        end else if (in_valid && in_ready) begin
            skid_data <= in_data;
        end
    end

endmodule

//--- design/fetch_top.sv
// Fetch subsystem top level
// Connects the fetch stage to the instruction memory over the cache
// request and response channels
`timescale 1ns/1ps

module fetch_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic                              schedule_valid,
    input  fetch_pkg::sched_req_t             schedule_data,
    output logic                              schedule_ready,
    input  logic [fetch_pkg::ISSUE_WIDTH-1:0] ibuf_pop,
    output logic                              fetch_valid,
    output fetch_pkg::fetch_data_t            fetch_data,
    input  logic                              fetch_ready
);
    import fetch_pkg::*;

    logic icache_req_valid;
    logic icache_req_ready;
    icache_req_t icache_req;
    logic icache_rsp_valid;
    logic icache_rsp_ready;
    icache_rsp_t icache_rsp;

    fetch_unit fetch (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .schedule_valid   (schedule_valid),
        .schedule_data    (schedule_data),
        .schedule_ready   (schedule_ready),
        .icache_req_valid (icache_req_valid),
        .icache_req       (icache_req),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp       (icache_rsp),
        .icache_rsp_ready (icache_rsp_ready),
        .ibuf_pop         (ibuf_pop),
        .fetch_valid      (fetch_valid),
        .fetch_data       (fetch_data),
        .fetch_ready      (fetch_ready)
    );

    icache_mem icache (
        .clk       (clk),
        .reset     (reset),
        .req_valid (icache_req_valid),
        .req       (icache_req),
        .req_ready (icache_req_ready),
        .rsp_valid (icache_rsp_valid),
        .rsp       (icache_rsp),
        .rsp_ready (icache_rsp_ready)
    );

endmodule

//--- design/fetch_unit.sv
// Instruction fetch stage
// Admits scheduler requests against per-slot instruction buffer credits,
// sends them to the instruction cache through a skid buffer, and pairs the
// in-order cache responses with their saved PC and thread mask.
// A mispredict flush squashes every response still owed by the cache
`timescale 1ns/1ps

module fetch_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic                              schedule_valid,
    input  fetch_pkg::sched_req_t             schedule_data,
    output logic                              schedule_ready,
    output logic                              icache_req_valid,
    output fetch_pkg::icache_req_t            icache_req,
    input  logic                              icache_req_ready,
    input  logic                              icache_rsp_valid,
    input  fetch_pkg::icache_rsp_t            icache_rsp,
    output logic                              icache_rsp_ready,
    input  logic [fetch_pkg::ISSUE_WIDTH-1:0] ibuf_pop,
    output logic                              fetch_valid,
    output fetch_pkg::fetch_data_t            fetch_data,
    input  logic                              fetch_ready
);
    import fetch_pkg::*;

    logic [$clog2(ISSUE_WIDTH)-1:0] sched_slot;
    logic [ISSUE_WIDTH-1:0] slot_incr;
    logic [ISSUE_WIDTH-1:0] credit_full;
    logic slot_has_credit;
    logic schedule_fire;
    logic buf_in_valid;
    logic buf_in_ready;
    logic buf_out_valid;
    logic buf_out_ready;
    icache_req_t buf_in_data;
    logic squashing;
    logic squash_active;
    logic req_fire;
    logic rsp_fire;
    logic fetch_fire;
    ibuf_cnt_t sent_count;
    ibuf_cnt_t sent_count_n;
    fetch_data_t tag_in;
    fetch_data_t tag_head;

    // slot is the warp id modulo the issue width
    assign sched_slot = schedule_data.wid[$clog2(ISSUE_WIDTH)-1:0];
    assign slot_has_credit = !credit_full[sched_slot];

    assign buf_in_valid = schedule_valid && slot_has_credit;
    assign schedule_ready = buf_in_ready && slot_has_credit;
    assign schedule_fire = schedule_valid && schedule_ready;

    assign buf_in_data.addr     = schedule_data.pc[XLEN-1:2];
    assign buf_in_data.tag.uuid = schedule_data.uuid;
    assign buf_in_data.tag.wid  = schedule_data.wid;

    fetch_req_buffer req_buf (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (buf_in_valid),
        .in_data   (buf_in_data),
        .in_ready  (buf_in_ready),
        .out_valid (buf_out_valid),
        .out_data  (icache_req),
        .out_ready (buf_out_ready)
    );

    // the flush cycle itself already counts as squashing
    assign squash_active = squashing || flush;

    // hold requests back while stale responses are still coming in
    assign buf_out_ready = icache_req_ready && !squash_active;
    assign icache_req_valid = buf_out_valid && !squash_active;
    assign req_fire = icache_req_valid && icache_req_ready;

    // the request buffer is in order, so contexts are queued as they are admitted
    assign tag_in.uuid  = schedule_data.uuid;
    assign tag_in.wid   = schedule_data.wid;
    assign tag_in.tmask = schedule_data.tmask;
    assign tag_in.pc    = schedule_data.pc;
    assign tag_in.instr = '0;

    fetch_fifo tag_store (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .push     (schedule_fire),
        .pop      (fetch_fire),
        .data_in  (tag_in),
        .data_out (tag_head)
    );

    always_comb begin
        slot_incr = '0;
        slot_incr[sched_slot] = schedule_fire;
    end

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_credit
        ibuf_credit credit (
            .clk   (clk),
            .reset (reset),
            .flush (flush),
            .incr  (slot_incr[i]),
            .decr  (ibuf_pop[i]),
            .full  (credit_full[i])
        );
    end

    // squashed responses are accepted and dropped without reaching the output
    assign fetch_valid = icache_rsp_valid && !squash_active;
    assign icache_rsp_ready = fetch_ready || squash_active;
    assign fetch_fire = fetch_valid && fetch_ready;
    assign rsp_fire = icache_rsp_valid && icache_rsp_ready;

    assign fetch_data.uuid  = icache_rsp.tag.uuid;
    assign fetch_data.wid   = icache_rsp.tag.wid;
    assign fetch_data.tmask = tag_head.tmask;
    assign fetch_data.pc    = tag_head.pc;
    assign fetch_data.instr = icache_rsp.data;

    always_comb begin
        sent_count_n = sent_count;
        if (req_fire && !rsp_fire) begin
            sent_count_n = sent_count + 1'b1;
        end else if (rsp_fire && !req_fire) begin
            sent_count_n = sent_count - 1'b1;
        end
    end

    // squashing ends once the cache owes no more responses
    always_ff @(posedge clk) begin
        if (reset) begin
            sent_count <= '0;
            squashing  <= 1'b0;
        end else begin
            sent_count <= sent_count_n;
            squashing  <= squash_active && (sent_count_n != '0);
        end
    end

endmodule

//--- design/ibuf_credit.sv
// Instruction buffer credit counter
// Tracks fetches in flight for one issue slot, i.e. admitted schedules
// minus entries popped from the instruction buffer
`timescale 1ns/1ps

module ibuf_credit (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic incr,
    input  logic decr,
    output logic full
);
    import fetch_pkg::*;

    ibuf_cnt_t count;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
        end else if (incr && !decr) begin
            count <= count + 1'b1;
        end else if (decr && !incr && count != '0) begin
            // a stray pop after a flush must not wrap the count
            count <= count - 1'b1;
        end
    end

    assign full = (count == ibuf_cnt_t'(IBUF_SIZE));

endmodule

//--- design/icache_mem.sv
// Instruction memory
// Fixed-latency, in-order read pipeline over a word array loaded from a hex
// image. Stage one registers the request, stage two the read data; the
// whole pipeline holds while the response is back-pressured
`timescale 1ns/1ps

module icache_mem (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  fetch_pkg::icache_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output fetch_pkg::icache_rsp_t rsp,
    input  logic                   rsp_ready
);
    import fetch_pkg::*;

    logic [XLEN-1:0] mem [IMEM_WORDS];

    logic stall;
    logic s1_valid;
    icache_tag_t s1_tag;
    logic [$clog2(IMEM_WORDS)-1:0] s1_index;
    logic s2_valid;
    icache_tag_t s2_tag;
    logic [XLEN-1:0] s2_data;

    initial begin
        $readmemh("test/program.hex", mem);
    end

    // only a waiting response can stall the pipeline
    assign stall = s2_valid && !rsp_ready;
    assign req_ready = !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req_valid;
            s2_valid <= s1_valid;
        end
    end

    // the array wraps on the low word address bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_tag   <= req.tag;
            s1_index <= req.addr[$clog2(IMEM_WORDS)-1:0];
            s2_tag   <= s1_tag;
            s2_data  <= mem[s1_index];
        end
    end

    assign rsp_valid = s2_valid;
    assign rsp.data  = s2_data;
    assign rsp.tag   = s2_tag;

endmodule

//--- test/fetch_tb.sv
// Fetch subsystem testbench
// Drives scheduler requests into the fetch top level, models the instruction
// buffer pops and compares every fetch output with a reference model
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam logic [31:0] SEED = 32'h7953;
    // 80 schedules over all tests, each allowed up to 50 cycles
    localparam int SCHED_TOTAL = 80;
    localparam int MAX_CYCLES = 50 * SCHED_TOTAL;
    // cycles an entry waits in the instruction buffer before it issues
    localparam int POP_DELAY = 3;
    // cycles the outstanding outputs get to arrive once the last schedule is in
    localparam int DRAIN_LIMIT = 200;

    typedef enum logic [1:0] {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_t;

    logic clk = 1'b0;
    logic reset;
    logic flush;
    logic schedule_valid;
    sched_req_t schedule_data;
    logic schedule_ready;
    logic [ISSUE_WIDTH-1:0] ibuf_pop = '0;
    logic fetch_valid;
    fetch_data_t fetch_data;
    logic fetch_ready = 1'b1;

    logic [XLEN-1:0] prog [IMEM_WORDS];
    fetch_data_t exp_q[$];
    // cycle at which each buffered entry of slot 0 and slot 1 may issue
    int due0[$];
    int due1[$];
    logic [ISSUE_WIDTH-1:0] pop_next = '0;
    int pop_asked = 0;
    int pop_done = 0;
    logic drain_on = 1'b1;
    ready_mode_t ready_mode = READY_HIGH;
    logic [UUID_WIDTH-1:0] next_uuid = '0;
    int cycle = 0;
    string test_name = "reset";

    fetch_top DUT (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .schedule_valid (schedule_valid),
        .schedule_data  (schedule_data),
        .schedule_ready (schedule_ready),
        .ibuf_pop       (ibuf_pop),
        .fetch_valid    (fetch_valid),
        .fetch_data     (fetch_data),
        .fetch_ready    (fetch_ready)
    );

    always #50 clk = ~clk;

    // the fetched word is the program word at PC bits 6:2
    function automatic fetch_data_t expected_fetch(input sched_req_t req);
        fetch_data_t want;
        want.uuid  = req.uuid;
        want.wid   = req.wid;
        want.tmask = req.tmask;
        want.pc    = req.pc;
        want.instr = prog[req.pc[6:2]];
        return want;
    endfunction

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("the run did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    // fetch_ready and the instruction buffer pops
    always begin : side_inputs
        logic [31:0] r_bit;
        @(posedge clk);
        #1;
        ibuf_pop = pop_next;
        r_bit = $urandom;
        case (ready_mode)
            READY_LOW:    fetch_ready = 1'b0;
            READY_RANDOM: fetch_ready = r_bit[0];
            default:      fetch_ready = 1'b1;
        endcase
    end

    // samples between edges, where every handshake is settled
    always @(negedge clk) begin : compare
        fetch_data_t want;
        if (reset) begin
            pop_next = '0;
        end else if (flush) begin
            exp_q.delete();
            due0.delete();
            due1.delete();
            pop_next = '0;
        end else begin
            if (schedule_valid && schedule_ready) begin
                exp_q.push_back(expected_fetch(schedule_data));
            end
            if (fetch_valid && fetch_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("%s: fetch output uuid %h with no schedule outstanding",
                             test_name, fetch_data.uuid);
                    stop_with_failure();
                end
                want = exp_q.pop_front();
                assert (fetch_data == want) else begin
                    $display("Error: %s: expected %h, actual %h", test_name, want, fetch_data);
                    stop_with_failure();
                end
                // slot is the warp id modulo two
                if (fetch_data.wid[0]) due1.push_back(cycle + POP_DELAY);
                else due0.push_back(cycle + POP_DELAY);
            end
            pop_next = '0;
            if (drain_on && due0.size() != 0 && due0[0] <= cycle) begin
                pop_next[0] = 1'b1;
                void'(due0.pop_front());
            end
            if (drain_on && due1.size() != 0 && due1[0] <= cycle) begin
                pop_next[1] = 1'b1;
                void'(due1.pop_front());
            end
            if (pop_asked != pop_done) begin
                pop_next[0] = 1'b1;
                if (due0.size() != 0) void'(due0.pop_front());
                pop_done = pop_done + 1;
            end
        end
    end

    task automatic offer_schedule(input logic [NW_WIDTH-1:0] wid, input logic [XLEN-1:0] pc,
                                  input logic [THREAD_CNT-1:0] tmask);
        schedule_data.uuid  = next_uuid;
        schedule_data.wid   = wid;
        schedule_data.tmask = tmask;
        schedule_data.pc    = pc;
        schedule_valid = 1'b1;
        next_uuid = next_uuid + 1'b1;
    endtask

    task automatic wait_accept();
        @(negedge clk);
        while (!schedule_ready) @(negedge clk);
        @(posedge clk);
        #1;
        schedule_valid = 1'b0;
    endtask

    task automatic random_schedule();
        logic [31:0] r_ctl;
        logic [31:0] r_pc;
        r_ctl = $urandom;
        r_pc = $urandom;
        offer_schedule(r_ctl[NW_WIDTH-1:0], {r_pc[31:2], 2'b00}, r_ctl[11:8]);
        wait_accept();
    endtask

    // returns once every output has arrived and the buffer model is empty,
    // or when the drain limit runs out with outputs still missing
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || due0.size() != 0 || due1.size() != 0)
               && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        @(posedge clk);
        #1;
    endtask

    initial begin : stimulus
        void'($urandom(SEED));
        $readmemh("test/program.hex", prog);
        reset = 1'b1;
        flush = 1'b0;
        schedule_valid = 1'b0;
        schedule_data = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "after reset";
        @(negedge clk);
        assert (!fetch_valid) else begin
            $display("Error: %s: fetch_valid expected 0, actual %b", test_name, fetch_valid);
            stop_with_failure();
        end
        @(posedge clk);
        #1;
        offer_schedule(2'd1, 32'h0000_0040, 4'b1111);
        @(negedge clk);
        assert (schedule_ready) else begin
            $display("Error: %s: schedule_ready expected 1, actual %b", test_name,
                     schedule_ready);
            stop_with_failure();
        end
        @(posedge clk);
        #1;
        schedule_valid = 1'b0;
        wait_drain();

        test_name = "single warp";
        for (int i = 0; i < 8; i++) begin
            offer_schedule(2'd0, 32'h0000_0100 + i * 4, 4'b1111);
            wait_accept();
        end
        wait_drain();

        test_name = "mixed warps";
        ready_mode <= READY_RANDOM;
        for (int i = 0; i < 48; i++) random_schedule();
        wait_drain();

        // slot 0 fills its credits while slot 1 keeps going
        test_name = "credit limit";
        ready_mode <= READY_HIGH;
        drain_on = 1'b0;
        for (int i = 0; i < IBUF_SIZE; i++) begin
            offer_schedule(2'd0, 32'h0000_0200 + i * 4, 4'b0011);
            wait_accept();
        end
        offer_schedule(2'd1, 32'h0000_0210, 4'b1100);
        wait_accept();
        offer_schedule(2'd2, 32'h0000_0214, 4'b0101);
        repeat (8) begin
            @(negedge clk);
            assert (!schedule_ready) else begin
                $display("Error: %s: schedule_ready expected 0, actual %b", test_name,
                         schedule_ready);
                stop_with_failure();
            end
        end
        @(posedge clk);
        #1;
        pop_asked = pop_asked + 1;
        wait_accept();
        drain_on = 1'b1;
        wait_drain();

        // responses pile up behind a stalled output, then get flushed
        test_name = "flush";
        ready_mode <= READY_LOW;
        for (int w = 0; w < NUM_WARPS; w++) begin
            offer_schedule(NW_WIDTH'(w), 32'h0000_0300 + w * 4, 4'b1010);
            wait_accept();
        end
        flush = 1'b1;
        ready_mode <= READY_RANDOM;
        @(posedge clk);
        #1;
        flush = 1'b0;
        for (int i = 0; i < 13; i++) random_schedule();
        wait_drain();

        test_name = "end of run";
        if (exp_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Error: %s: expected 0 pending outputs, actual %0d", test_name,
                     exp_q.size());
            stop_with_failure();
        end
    end

endmodule

//--- test/program.hex
// one 32-bit instruction word per line, word addresses 0 to 31 (addi x1, x0, address)
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00A00093
00B00093
00C00093
00D00093
00E00093
00F00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01A00093
01B00093
01C00093
01D00093
01E00093
01F00093

//--- vlog.f
design/fetch_pkg.sv
design/fetch_fifo.sv
design/ibuf_credit.sv
design/fetch_req_buffer.sv
design/fetch_unit.sv
design/icache_mem.sv
design/fetch_top.sv
test/fetch_tb.sv
